/* design/repack_defs.svh */
`ifndef REPACK_DEFS_SVH
`define REPACK_DEFS_SVH

// Converter side sample width
`define RS_SAMPLE_W 16

// Consumer side width, two samples per transfer
`define RS_PAIR_W 32

// Packed word between the two resizers, four samples
`define RS_WORD_W 64

// Words held by the buffer stage
`define RS_FIFO_DEPTH 4

`endif

/* design/repack_pkg.sv */
`default_nettype none

package repack_pkg;

	`include "repack_defs.svh"

	// One converter sample
	typedef logic [`RS_SAMPLE_W-1:0] sample_t;

	// Two samples, earlier one in the low half
	typedef logic [`RS_PAIR_W-1:0] pair_t;

	// Four samples, earliest in the low bits
	typedef logic [`RS_WORD_W-1:0] word_t;

endpackage

`default_nettype wire

/* design/util_axis_resize.sv */
`timescale 1ns/1ps
`default_nettype none

// Stream width converter
// Equal widths pass straight through, a narrow input is packed into wide
// words and a wide input is split into narrow pieces
module util_axis_resize #(
	parameter int s_data_width = 64,
	parameter int m_data_width = 64,
	parameter bit big_endian = 1'b0
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    s_valid,
	output logic                    s_ready,
	input  logic [s_data_width-1:0] s_data,
	output logic                    m_valid,
	input  logic                    m_ready,
	output logic [m_data_width-1:0] m_data
);

	generate
		if (s_data_width == m_data_width) begin : g_equal

			// Zero latency
			assign m_valid = s_valid;
			assign s_ready = m_ready;
			assign m_data = s_data;

		end else if (s_data_width < m_data_width) begin : g_up

			localparam int ratio = m_data_width / s_data_width;
			localparam int cnt_w = $clog2(ratio);

			logic [m_data_width-1:0] data;
			logic [cnt_w-1:0] count;    // Inputs still missing, minus one
			logic valid;
			logic s_fire;
			logic group_end;

			assign s_fire = s_valid && s_ready;
			assign group_end = (count == '0);

			always_ff @(posedge clk) begin
				if (!resetn) begin
					count <= cnt_w'(ratio - 1);
					valid <= 1'b0;
				end else begin
					if (s_fire && group_end)
						valid <= 1'b1;
					else if (m_ready)
						valid <= 1'b0;

					if (s_fire) begin
						if (group_end)
							count <= cnt_w'(ratio - 1);
						else
							count <= count - 1'b1;
					end
				end
			end

			// Shift register collecting one group
			always_ff @(posedge clk) begin
				if (s_fire) begin
					if (big_endian) begin
						// First input ends up in the high bits
						data <= {data[m_data_width-s_data_width-1:0], s_data};
					end else begin
						// First input ends up in the low bits
						data <= {s_data, data[m_data_width-1:s_data_width]};
					end
				end
			end

			// Full word may still be taken while the next group arrives
			assign s_ready = !valid || m_ready;
			assign m_valid = valid;
			assign m_data = data;

		end else begin : g_down

			localparam int ratio = s_data_width / m_data_width;
			localparam int cnt_w = $clog2(ratio);

			logic [s_data_width-1:0] data;
			logic [cnt_w-1:0] count;    // Pieces left after the current one
			logic valid;
			logic s_fire;
			logic m_fire;
			logic last_piece;

			assign s_fire = s_valid && s_ready;
			assign m_fire = valid && m_ready;
			assign last_piece = (count == '0);

			always_ff @(posedge clk) begin
				if (!resetn) begin
					count <= cnt_w'(ratio - 1);
					valid <= 1'b0;
				end else begin
					if (s_fire)
						valid <= 1'b1;
					else if (m_fire && last_piece)
						valid <= 1'b0;

					if (m_fire) begin
						if (last_piece)
							count <= cnt_w'(ratio - 1);
						else
							count <= count - 1'b1;
					end
				end
			end

			// Load on input, shift one piece out per output transfer
			always_ff @(posedge clk) begin
				if (s_fire) begin
					data <= s_data;
				end else if (m_fire) begin
					if (big_endian) begin
						data <= {data[s_data_width-m_data_width-1:0],
							{m_data_width{1'b0}}};
					end else begin
						data <= {{m_data_width{1'b0}},
							data[s_data_width-1:m_data_width]};
					end
				end
			end

			// Empty, or the last piece leaves this cycle
			assign s_ready = !valid || (m_ready && last_piece);
			assign m_valid = valid;

			if (big_endian) begin : g_be
				assign m_data = data[s_data_width-1:s_data_width-m_data_width];
			end else begin : g_le
				assign m_data = data[m_data_width-1:0];
			end

		end
	endgenerate

endmodule

`default_nettype wire

/* design/axis_word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Word buffer with a registered output stage
// The occupancy count covers both the storage and the output register
module axis_word_fifo
	import repack_pkg::*;
#(
	parameter int depth = 4
) (
	input  logic  clk,
	input  logic  resetn,
	input  logic  s_valid,
	output logic  s_ready,
	input  word_t s_data,
	output logic  m_valid,
	input  logic  m_ready,
	output word_t m_data
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	word_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic out_valid;
	word_t out_data;

	logic wr_fire;
	logic rd_fire;
	logic load;          // Output register free after this edge
	logic stor_empty;
	logic bypass;        // Write goes straight to the output register
	logic push;
	logic pop;
	logic full;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign full = (count == cnt_w'(depth));
	assign rd_fire = out_valid && m_ready;

	// Full but draining still accepts a word
	assign s_ready = !full || rd_fire;
	assign wr_fire = s_valid && s_ready;

	assign load = !out_valid || m_ready;
	assign stor_empty = (count == cnt_w'(out_valid));
	assign bypass = load && stor_empty && wr_fire;
	assign push = wr_fire && !bypass;
	assign pop = load && !stor_empty;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			count <= count + cnt_w'(wr_fire) - cnt_w'(rd_fire);

			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			if (load)
				out_valid <= pop || bypass;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= s_data;
	end

	// Oldest stored word first, else the incoming one
	always_ff @(posedge clk) begin
		if (pop)
			out_data <= mem[rd_ptr];
		else if (bypass)
			out_data <= s_data;
	end

	assign m_valid = out_valid;
	assign m_data = out_data;

endmodule

`default_nettype wire

/* design/sample_repack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "repack_defs.svh"

// Sample repacker
// 16-bit samples are packed four to a word, buffered, then handed
// out two at a time, earliest sample always in the low bits
module sample_repack
	import repack_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,

	// Converter side
	input  logic    in_valid,
	output logic    in_ready,
	input  sample_t in_data,

	// Consumer side
	output logic    out_valid,
	input  logic    out_ready,
	output pair_t   out_data
);

	// Packer to buffer
	logic  up_valid;
	logic  up_ready;
	word_t up_data;

	// Buffer to unpacker
	logic  buf_valid;
	logic  buf_ready;
	word_t buf_data;

	util_axis_resize #(
		.s_data_width (`RS_SAMPLE_W),
		.m_data_width (`RS_WORD_W),
		.big_endian   (1'b0)
	) u_pack (
		.clk     (clk),
		.resetn  (resetn),
		.s_valid (in_valid),
		.s_ready (in_ready),
		.s_data  (in_data),
		.m_valid (up_valid),
		.m_ready (up_ready),
		.m_data  (up_data)
	);

	axis_word_fifo #(
		.depth (`RS_FIFO_DEPTH)
	) u_buf (
		.clk     (clk),
		.resetn  (resetn),
		.s_valid (up_valid),
		.s_ready (up_ready),
		.s_data  (up_data),
		.m_valid (buf_valid),
		.m_ready (buf_ready),
		.m_data  (buf_data)
	);

	util_axis_resize #(
		.s_data_width (`RS_WORD_W),
		.m_data_width (`RS_PAIR_W),
		.big_endian   (1'b0)
	) u_unpack (
		.clk     (clk),
		.resetn  (resetn),
		.s_valid (buf_valid),
		.s_ready (buf_ready),
		.s_data  (buf_data),
		.m_valid (out_valid),
		.m_ready (out_ready),
		.m_data  (out_data)
	);

endmodule

`default_nettype wire

/* testbench/sample_repack_assert.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake checks on the repacker ports
module sample_repack_assert
	import repack_pkg::*;
(
	input  logic  clk,
	input  logic  resetn,
	input  logic  in_ready,
	input  logic  out_valid,
	input  logic  out_ready,
	input  pair_t out_data
);

	int fail_count = 0;

	// A stalled pair must not move or vanish
	property p_out_hold;
		@(posedge clk) disable iff (!resetn)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data));
	endproperty

	property p_in_ready_known;
		@(posedge clk) disable iff (!resetn)
		!$isunknown(in_ready);
	endproperty

	// First edge that sees reset released
	property p_out_idle_after_reset;
		@(posedge clk) $rose(resetn) |-> !out_valid;
	endproperty

	a_out_hold: assert property (p_out_hold)
		else begin
			fail_count++;
			$error("out_valid or out_data changed while out_ready was low");
		end

	a_in_ready_known: assert property (p_in_ready_known)
		else begin
			fail_count++;
			$error("in_ready is unknown");
		end

	a_out_idle_after_reset: assert property (p_out_idle_after_reset)
		else begin
			fail_count++;
			$error("out_valid high in the first cycle after reset");
		end

endmodule

bind sample_repack sample_repack_assert u_assert (
	.clk       (clk),
	.resetn    (resetn),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data)
);

`default_nettype wire

/* testbench/tb_sample_repack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "repack_defs.svh"

module tb_sample_repack
	import repack_pkg::*;
();

	localparam int send_limit = 64;     // Cycles a sample may wait for in_ready
	localparam int drain_limit = 2000;
	localparam int stall_cap = (`RS_FIFO_DEPTH + 2) * 4;

	logic    clk;
	logic    resetn;
	logic    in_valid;
	logic    in_ready;
	sample_t in_data;
	logic    out_valid;
	logic    out_ready;
	pair_t   out_data;

	sample_t model_q[$];    // Accepted, not yet seen at the output
	pair_t   got_q[$];
	int      out_count;
	int      errors;
	int      timeouts;

	sample_repack u_dut (
		.clk       (clk),
		.resetn    (resetn),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#2000000;
		$display("Timeout: simulation did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_pair(input string name, input pair_t exp, input pair_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_empty(input string test);
		if (model_q.size() != 0) begin
			errors++;
			$display("%s: %0d accepted samples never reached the output", test,
				model_q.size());
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// Both sides sampled mid cycle, where they are settled
	always @(negedge clk) begin : monitor
		pair_t exp;
		if (resetn) begin
			if (out_valid && out_ready) begin
				got_q.push_back(out_data);
				out_count++;
				if (model_q.size() < 2) begin
					errors++;
					$display("Pair at %0t arrived with fewer than two samples pending", $time);
				end else begin
					exp = {model_q[1], model_q[0]};   // Later sample in the high half
					void'(model_q.pop_front());
					void'(model_q.pop_front());
					check_pair("out_data", exp, out_data);
				end
			end
			if (in_valid && in_ready)
				model_q.push_back(in_data);
		end
	end

	task automatic send_sample(input sample_t s);
		int waited;
		logic taken;
		in_valid = 1'b1;
		in_data = s;
		waited = 0;
		taken = 1'b0;
		while (!taken && waited < send_limit) begin
			@(negedge clk);
			taken = in_ready;
			step_cycle();
			waited++;
		end
		in_valid = 1'b0;
		if (!taken) begin
			timeouts++;
			$display("Timeout: sample %h not accepted within %0d cycles", s, send_limit);
		end
	endtask

	task automatic wait_pairs(input int target);
		int cycles;
		cycles = 0;
		while (out_count < target && cycles < drain_limit) begin
			step_cycle();
			cycles++;
		end
		if (out_count < target) begin
			timeouts++;
			$display("Timeout: %0d of %0d pairs arrived", out_count, target);
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_level("out_valid", 1'b0, out_valid);
		check_level("in_ready", 1'b1, in_ready);
		step_cycle();
	endtask

	task automatic one_group();
		sample_t s [4];
		int base;
		int start;
		s = '{16'h1a01, 16'h2b02, 16'h3c03, 16'h4d04};
		base = got_q.size();
		start = out_count;
		out_ready = 1'b1;
		for (int i = 0; i < 4; i++)
			send_sample(s[i]);
		wait_pairs(start + 2);
		if (got_q.size() >= base + 2) begin
			check_pair("out_data first pair", {s[1], s[0]}, got_q[base]);
			check_pair("out_data second pair", {s[3], s[2]}, got_q[base + 1]);
		end
		step_cycle();
		@(negedge clk);
		check_level("out_valid", 1'b0, out_valid);
		step_cycle();
	endtask

	task automatic continuous_stream();
		int start;
		start = out_count;
		out_ready = 1'b1;
		for (int i = 0; i < 64; i++)
			send_sample(sample_t'($urandom));
		wait_pairs(start + 32);
		check_empty("continuous stream");
	endtask

	task automatic full_backpressure();
		int accepted;
		int cycles;
		int start;
		logic stalled;
		out_ready = 1'b0;
		accepted = 0;
		cycles = 0;
		stalled = 1'b0;
		in_valid = 1'b1;
		in_data = sample_t'($urandom);
		while (!stalled && cycles < stall_cap + 8) begin
			@(negedge clk);
			if (in_ready)
				accepted++;
			else
				stalled = 1'b1;
			step_cycle();
			if (!stalled)
				in_data = sample_t'($urandom);
			cycles++;
		end
		in_valid = 1'b0;
		if (!stalled) begin
			timeouts++;
			$display("Timeout: in_ready never fell with out_ready held low");
		end
		if (accepted > stall_cap) begin
			errors++;
			$display("Pipe took %0d samples under back-pressure, limit is %0d",
				accepted, stall_cap);
		end
		repeat (4) step_cycle();
		@(negedge clk);
		check_level("in_ready", 1'b0, in_ready);
		check_level("out_valid", 1'b1, out_valid);
		step_cycle();
		start = out_count;
		out_ready = 1'b1;
		wait_pairs(start + accepted / 2);
		check_empty("full back-pressure");
	endtask

	task automatic random_gaps();
		int start;
		bit sending;
		start = out_count;
		sending = 1'b1;
		fork
			begin
				for (int i = 0; i < 200; i++) begin
					repeat ($urandom % 3) step_cycle();
					send_sample(sample_t'($urandom));
				end
				sending = 1'b0;
			end
			begin
				while (sending) begin
					out_ready = ($urandom % 2) != 0;
					step_cycle();
				end
			end
		join
		out_ready = 1'b1;
		wait_pairs(start + 100);
		check_empty("random gaps");
	endtask

	initial begin
		void'($urandom(32'hb7df));
		resetn = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		errors = 0;
		timeouts = 0;
		out_count = 0;
		repeat (8) @(posedge clk);
		#1;
		resetn = 1'b1;

		check_reset_state();
		one_group();
		continuous_stream();
		full_backpressure();
		random_gaps();

		errors += u_dut.u_assert.fail_count;
		$display("Done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+design
design/repack_pkg.sv
design/util_axis_resize.sv
design/axis_word_fifo.sv
design/sample_repack.sv
testbench/sample_repack_assert.sv
testbench/tb_sample_repack.sv

/* run.sh */
#!/bin/sh
# Build and run the sample repacker testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sample_repack \
	-Mdir obj_dir -f all.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_sample_repack > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
